// File: tmu_config.svh
// width settings for the trellis metric unit of the 4D-8PSK TCM decoder
// include before the package and in every unit that sizes its own vectors
// all widths are in bits

`ifndef TMU_CONFIG_SVH
`define TMU_CONFIG_SVH

// soft metric of one 8PSK point, smaller is closer
`define SYMB_M_W  8

`define SIGN_W    2                 // sign field per 2D dimension

// sum of four point metrics needs two extra bits
`define BM_W      (`SYMB_M_W + 2)

`define IDX_W     4                 // up to 16 candidates per group
`define PNT_W     3                 // 8PSK point index

// hard decision holds one point index per dimension
`define HD_W      (4 * `PNT_W)

`endif

// File: tcm_dec_pkg.sv
// shared types of the TCM decoder trellis metric unit
// import with a wildcard in the module header where needed
// widths come from the config header

`default_nettype none

`include "tmu_config.svh"

package tcm_dec_pkg;

  //--------------------
  // data types
  //--------------------

  typedef logic [`SYMB_M_W-1:0] symb_m_t;       // one point metric
  typedef logic [`SIGN_W-1:0]   symb_m_sign_t;  // signs of one dimension
  typedef logic [`BM_W-1:0]     bm_t;           // 4D branch metric
  typedef logic [`IDX_W-1:0]    symb_m_idx_t;   // winning candidate in a group

  // dimension z sits at bits [3z+2:3z]
  typedef logic [`HD_W-1:0]     symb_hd_t;

  //--------------------
  // code setting
  //--------------------

  // candidate count per group is 2, 4, 8 or 16
  typedef enum logic [1:0] {
    CODE_G2  = 2'd0,
    CODE_G4  = 2'd1,
    CODE_G8  = 2'd2,
    CODE_G16 = 2'd3
  } code_t;

  // 8 and 16 candidates need the extra compare level
  function automatic logic code_long(code_t code);
    return (code == CODE_G8) || (code == CODE_G16);
  endfunction

endpackage

`default_nettype wire

// File: tcm_dec_tmu_tree.sv
// add and compare tree for one symbol group of the trellis metric unit
// sums four dimension metrics per candidate and finds the minimum sum
// N is the candidate count, 2 or 4 give 2 stages, 8 or 16 give 3 stages
// ties go to the lower candidate index

`timescale 1ns/1ps
`default_nettype none

`include "tmu_config.svh"

module tcm_dec_tmu_tree
  import tcm_dec_pkg::*;
#(
  parameter int N = 4   // candidates, one of 2, 4, 8, 16
)(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  //
  input  logic        ival,
  input  symb_m_t     isymb_m [N][4],   // [candidate][dimension]
  //
  output logic        oval,
  output bm_t         obm,              // minimum 4D metric
  output symb_m_idx_t osymb_m_idx       // its candidate index
);

  localparam int cLAT = (N > 4) ? 3 : 2;       // pipeline depth
  localparam int cPAD = `BM_W - `SYMB_M_W;     // extension bits for the sum

  //--------------------
  // valid pipeline
  //--------------------

  logic [cLAT-1:0] val_pipe;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_pipe <= '0;
    end else if (iclkena) begin
      val_pipe <= {val_pipe[cLAT-2:0], ival};
    end
  end

  assign oval = val_pipe[cLAT-1];

  //--------------------
  // stage 1 sums
  //--------------------

  bm_t ext_m [N][4];  // zero-extended point metrics
  bm_t sum   [N];     // registered 4D metric per candidate

  always_comb begin
    for (int c = 0; c < N; c++) begin
      for (int z = 0; z < 4; z++) begin
        ext_m[c][z] = {{cPAD{1'b0}}, isymb_m[c][z]};
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int c = 0; c < N; c++) begin
        sum[c] <= ext_m[c][0] + ext_m[c][1] + ext_m[c][2] + ext_m[c][3];
      end
    end
  end

  //--------------------
  // compare levels
  //--------------------

  if (N <= 4) begin : g_short

    bm_t         min_bm;
    symb_m_idx_t min_idx;

    // strict less keeps the lower index on equal sums
    always_comb begin
      min_bm  = sum[0];
      min_idx = '0;
      for (int c = 1; c < N; c++) begin
        if (sum[c] < min_bm) begin
          min_bm  = sum[c];
          min_idx = symb_m_idx_t'(c);
        end
      end
    end

    always_ff @(posedge iclk) begin
      if (iclkena) begin
        obm         <= min_bm;   // stage 2
        osymb_m_idx <= min_idx;
      end
    end

  end else begin : g_long

    localparam int cPART = N / 4;   // groups of four candidates

    bm_t         lvl_bm   [cPART];  // level A winners, comb
    symb_m_idx_t lvl_idx  [cPART];
    bm_t         part_bm  [cPART];  // level A winners, registered
    symb_m_idx_t part_idx [cPART];
    bm_t         min_bm;
    symb_m_idx_t min_idx;

    // level A picks the best of each group of four
    always_comb begin
      for (int p = 0; p < cPART; p++) begin
        lvl_bm[p]  = sum[4*p];
        lvl_idx[p] = symb_m_idx_t'(4*p);
        for (int k = 1; k < 4; k++) begin
          if (sum[4*p+k] < lvl_bm[p]) begin
            lvl_bm[p]  = sum[4*p+k];
            lvl_idx[p] = symb_m_idx_t'(4*p + k);
          end
        end
      end
    end

    always_ff @(posedge iclk) begin
      if (iclkena) begin
        part_bm  <= lvl_bm;    // stage 2
        part_idx <= lvl_idx;
      end
    end

    // level B over the partial winners, lower group first
    always_comb begin
      min_bm  = part_bm[0];
      min_idx = part_idx[0];
      for (int p = 1; p < cPART; p++) begin
        if (part_bm[p] < min_bm) begin
          min_bm  = part_bm[p];
          min_idx = part_idx[p];
        end
      end
    end

    always_ff @(posedge iclk) begin
      if (iclkena) begin
        obm         <= min_bm;   // stage 3
        osymb_m_idx <= min_idx;
      end
    end

  end

  // winner must come from the candidate set in use
  a_idx_range : assert property (@(posedge iclk) disable iff (ireset)
    oval |-> (int'(osymb_m_idx) < N));

endmodule

`default_nettype wire

// File: tcm_dec_tmu_hd.sv
// 4D hard decision for the trellis metric unit
// picks the closest 8PSK point in each dimension, two register stages
// lower point index wins on equal metrics

`timescale 1ns/1ps
`default_nettype none

`include "tmu_config.svh"

module tcm_dec_tmu_hd
  import tcm_dec_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     iclkena,
  //
  input  logic     ival,
  input  symb_m_t  isymb_m [4][8],   // [dimension][point]
  //
  output logic     oval,
  output symb_hd_t ohd
);

  symb_m_t           cand_m   [4][2];  // best of each half, comb
  logic [`PNT_W-1:0] cand_idx [4][2];
  symb_m_t           half_m   [4][2];  // stage 1 registers
  logic [`PNT_W-1:0] half_idx [4][2];
  logic [1:0]        val_pipe;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_pipe <= '0;
    end else if (iclkena) begin
      val_pipe <= {val_pipe[0], ival};
    end
  end

  assign oval = val_pipe[1];

  //--------------------
  // stage 1 halves
  //--------------------

  // points 0..3 and 4..7 are scanned apart
  always_comb begin
    for (int z = 0; z < 4; z++) begin
      for (int h = 0; h < 2; h++) begin
        cand_m[z][h]   = isymb_m[z][4*h];
        cand_idx[z][h] = {h[0], 2'b00};
        for (int k = 1; k < 4; k++) begin
          if (isymb_m[z][4*h+k] < cand_m[z][h]) begin
            cand_m[z][h]   = isymb_m[z][4*h+k];
            cand_idx[z][h] = {h[0], k[1:0]};
          end
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      half_m   <= cand_m;
      half_idx <= cand_idx;
    end
  end

  //--------------------
  // stage 2 final
  //--------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int z = 0; z < 4; z++) begin
        // upper half only if strictly closer
        ohd[z*`PNT_W +: `PNT_W] <= (half_m[z][1] < half_m[z][0]) ? half_idx[z][1]
                                                                  : half_idx[z][0];
      end
    end
  end

endmodule

`default_nettype wire

// File: tcm_dec_tmu.sv
// trellis metric unit top of the 4D-8PSK TCM decoder
// maps point metrics to candidate 4D points for all 16 groups, runs the
// four tree banks in parallel and outputs the bank that icode selects
// latency is 3 enabled edges for CODE_G2/G4 and 4 for CODE_G8/G16
// icode may change only while no beat is in flight

`timescale 1ns/1ps
`default_nettype none

`include "tmu_config.svh"

module tcm_dec_tmu
  import tcm_dec_pkg::*;
(
  input  logic         iclk,
  input  logic         ireset,
  input  logic         iclkena,
  //
  input  code_t        icode,
  //
  input  logic         isop,
  input  logic         ival,
  input  logic         ieop,
  input  symb_m_t      isymb_m      [4][8],  // [dimension][point]
  input  symb_m_sign_t isymb_m_sign [4],
  //
  output logic         osop,
  output logic         oval,
  output logic         oeop,
  //
  output bm_t          obm          [16],    // per group minimum metric
  output symb_m_idx_t  osymb_m_idx  [16],    // per group winning candidate
  output symb_m_sign_t osymb_m_sign [4],
  output symb_hd_t     osymb_hd
);

  //--------------------
  // candidate mapping
  //--------------------

  symb_m_t map_m [16][16][4];  // [group][candidate][dimension]

  // point bits are {c[z]^c[z+1], c[z], g[z]}, dimension index wraps at 4
  always_comb begin
    logic [3:0]        gb;
    logic [3:0]        cb;
    logic [`PNT_W-1:0] pnt;
    for (int g = 0; g < 16; g++) begin
      for (int c = 0; c < 16; c++) begin
        for (int z = 0; z < 4; z++) begin
          gb  = g[3:0];
          cb  = c[3:0];
          pnt = {cb[z] ^ cb[(z + 1) % 4], cb[z], gb[z]};
          map_m[g][c][z] = isymb_m[z][pnt];
        end
      end
    end
  end

  //--------------------
  // delay chains
  //--------------------

  logic [3:1]   val;                 // bit k holds the beat k edges back
  logic [3:1]   sop;
  logic [3:1]   eop;
  symb_m_sign_t sign_line [1:3][4];
  symb_hd_t     hd_ohd;              // hard decision, 2 edges
  symb_hd_t     hd_d;                // one more edge for long codes

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val <= '0;
      sop <= '0;
      eop <= '0;
    end else if (iclkena) begin
      val <= {val[2:1], ival};
      sop <= {sop[2:1], isop & ival};  // framing only on real beats
      eop <= {eop[2:1], ieop & ival};
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sign_line[1] <= isymb_m_sign;
      sign_line[2] <= sign_line[1];
      sign_line[3] <= sign_line[2];
      hd_d         <= hd_ohd;
    end
  end

  //--------------------
  // tree banks
  //--------------------

  bm_t         bank_bm  [4][16];  // [bank][group]
  symb_m_idx_t bank_idx [4][16];

  for (genvar b = 0; b < 4; b++) begin : g_bank
    localparam int cN = 2 << b;     // bank b serves code b

    for (genvar g = 0; g < 16; g++) begin : g_grp
      symb_m_t tree_m [cN][4];

      // first cN candidates of the full map
      always_comb begin
        for (int c = 0; c < cN; c++) begin
          for (int z = 0; z < 4; z++) begin
            tree_m[c][z] = map_m[g][c][z];
          end
        end
      end

      // valid timing comes from the val chain below
      tcm_dec_tmu_tree #(
        .N (cN)
      ) u_tree (
        .iclk        (iclk),
        .ireset      (ireset),
        .iclkena     (iclkena),
        .ival        (ival),
        .isymb_m     (tree_m),
        .oval        (),
        .obm         (bank_bm[b][g]),
        .osymb_m_idx (bank_idx[b][g])
      );
    end
  end

  //--------------------
  // hard decision
  //--------------------

  tcm_dec_tmu_hd u_hd (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isymb_m (isymb_m),
    .oval    (),
    .ohd     (hd_ohd)
  );

  //--------------------
  // output select
  //--------------------

  logic         is_long;
  logic         out_val;
  logic         out_sop;
  logic         out_eop;
  symb_m_sign_t out_sign [4];
  symb_hd_t     out_hd;
  bm_t          sel_bm   [16];
  symb_m_idx_t  sel_idx  [16];

  assign is_long = code_long(icode);
  assign out_val = is_long ? val[3] : val[2];
  assign out_sop = is_long ? sop[3] : sop[2];
  assign out_eop = is_long ? eop[3] : eop[2];
  assign out_hd  = is_long ? hd_d : hd_ohd;

  always_comb begin
    for (int z = 0; z < 4; z++) begin
      out_sign[z] = is_long ? sign_line[3][z] : sign_line[2][z];
    end
    for (int g = 0; g < 16; g++) begin
      sel_bm[g]  = bank_bm[icode][g];   // bank index equals code value
      sel_idx[g] = bank_idx[icode][g];
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval     <= 1'b0;
      osop     <= 1'b0;
      oeop     <= 1'b0;
      osymb_hd <= '0;
      for (int g = 0; g < 16; g++) begin
        obm[g]         <= '0;
        osymb_m_idx[g] <= '0;
      end
      for (int z = 0; z < 4; z++) begin
        osymb_m_sign[z] <= '0;
      end
    end else if (iclkena) begin
      oval <= out_val;
      osop <= out_sop;   // zero between beats
      oeop <= out_eop;
      if (out_val) begin
        obm          <= sel_bm;
        osymb_m_idx  <= sel_idx;
        osymb_m_sign <= out_sign;
        osymb_hd     <= out_hd;
      end
    end
  end

  //--------------------
  // checks
  //--------------------

  a_reset_idle : assert property (@(posedge iclk) ireset |-> !oval);

  // latency and bank choice both follow icode
  a_code_stable : assert property (@(posedge iclk) disable iff (ireset)
    (|val) |-> $stable(icode));

endmodule

`default_nettype wire

// File: tb_tcm_dec_tmu.sv
// testbench for the trellis metric unit top
// drives random beats from an LCG, recomputes the group minima and the hard
// decision in a model and checks every output beat against a queue
// six tests of 200 beats each, two codes per test

`timescale 1ns/1ps
`default_nettype none

`include "tmu_config.svh"

module tb_tcm_dec_tmu
  import tcm_dec_pkg::*;
();

  localparam int BEATS   = 200;                 // per test
  localparam int TIMEOUT = 6 * BEATS * 2 + 600;  // cycles, with margin

  // expected result of one beat
  typedef struct packed {
    logic [16*`BM_W-1:0] bm;
    logic [63:0]         idx;
    logic [`HD_W-1:0]    hd;
    logic [7:0]          sign;
    logic                sop;
    logic                eop;
    logic [31:0]         edge_no;   // capture edge
    logic [31:0]         lat;
  } exp_t;

  logic         iclk = 1'b0;
  logic         ireset;
  logic         iclkena;
  code_t        icode;
  logic         isop;
  logic         ival;
  logic         ieop;
  symb_m_t      isymb_m      [4][8];
  symb_m_sign_t isymb_m_sign [4];
  logic         osop;
  logic         oval;
  logic         oeop;
  bm_t          obm          [16];
  symb_m_idx_t  osymb_m_idx  [16];
  symb_m_sign_t osymb_m_sign [4];
  symb_hd_t     osymb_hd;

  exp_t        exp_q[$];
  logic [31:0] lcg_state;
  string       test_name;
  int          errors;
  int          beats_checked;
  int          beats_sent;
  int          frame_left;       // beats left in the current frame
  int          edge_cnt;         // enabled edges out of reset
  int          cycle_cnt;

  tcm_dec_tmu u_dut (
    .iclk         (iclk),
    .ireset       (ireset),
    .iclkena      (iclkena),
    .icode        (icode),
    .isop         (isop),
    .ival         (ival),
    .ieop         (ieop),
    .isymb_m      (isymb_m),
    .isymb_m_sign (isymb_m_sign),
    .osop         (osop),
    .oval         (oval),
    .oeop         (oeop),
    .obm          (obm),
    .osymb_m_idx  (osymb_m_idx),
    .osymb_m_sign (osymb_m_sign),
    .osymb_hd     (osymb_hd)
  );

  always #4 iclk = ~iclk;   // 8 ns period

  // --------------------
  // random source and model
  // --------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return (int'(r[23:8]) % 100) < pct;
  endfunction

  // expected outputs of the beat on the inputs right now
  function automatic exp_t model_beat(input code_t code);
    exp_t e;
    int   n;
    int   s;
    int   best;
    int   best_c;
    int   pnt;
    int   bp;
    case (code)
      CODE_G2: n = 2;
      CODE_G4: n = 4;
      CODE_G8: n = 8;
      default: n = 16;
    endcase
    for (int g = 0; g < 16; g++) begin
      best   = 0;
      best_c = 0;
      for (int c = 0; c < n; c++) begin
        s = 0;
        for (int z = 0; z < 4; z++) begin
          // bit0 from group, bit1 from candidate, bit2 from two candidate bits
          pnt = ((g >> z) & 1) + 2 * ((c >> z) & 1)
              + 4 * (((c >> z) ^ (c >> ((z + 1) % 4))) & 1);
          s = s + int'(isymb_m[z][pnt]);
        end
        if (c == 0 || s < best) begin   // lower candidate keeps ties
          best   = s;
          best_c = c;
        end
      end
      e.bm[g*`BM_W +: `BM_W] = bm_t'(best);
      e.idx[g*4 +: 4]        = symb_m_idx_t'(best_c);
    end
    for (int z = 0; z < 4; z++) begin
      bp = 0;
      for (int p = 1; p < 8; p++) begin
        if (isymb_m[z][p] < isymb_m[z][bp]) bp = p;
      end
      e.hd[z*3 +: 3]   = 3'(bp);
      e.sign[z*2 +: 2] = isymb_m_sign[z];
    end
    e.sop     = isop;
    e.eop     = ieop;
    e.edge_no = edge_cnt;
    e.lat     = (n > 4) ? 4 : 3;
    return e;
  endfunction

  // --------------------
  // checker
  // --------------------

  task automatic report_fault(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
  endtask

  task automatic compare(input string field, input logic [159:0] exp_v,
                         input logic [159:0] act_v);
    assert (act_v == exp_v) else begin
      $display("error %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_outputs();
    exp_t                e;
    logic [16*`BM_W-1:0] bm_act;
    logic [63:0]         idx_act;
    logic [7:0]          sign_act;
    if (!oval) begin
      assert (!osop && !oeop) else report_fault("osop or oeop high without oval");
    end else if (exp_q.size() == 0) begin
      report_fault("oval with no beat in flight");
    end else begin
      e = exp_q.pop_front();
      for (int g = 0; g < 16; g++) begin
        bm_act[g*`BM_W +: `BM_W] = obm[g];
        idx_act[g*4 +: 4]        = osymb_m_idx[g];
      end
      for (int z = 0; z < 4; z++) sign_act[z*2 +: 2] = osymb_m_sign[z];
      compare("latency", 160'(e.lat), 160'(edge_cnt - int'(e.edge_no) + 1));
      compare("obm", 160'(e.bm), 160'(bm_act));
      compare("osymb_m_idx", 160'(e.idx), 160'(idx_act));
      compare("osymb_hd", 160'(e.hd), 160'(osymb_hd));
      compare("osymb_m_sign", 160'(e.sign), 160'(sign_act));
      compare("osop", 160'(e.sop), 160'(osop));
      compare("oeop", 160'(e.eop), 160'(oeop));
      beats_checked++;
    end
  endtask

  // model at the edge, outputs 2 ns later when settled
  always @(posedge iclk) begin : check_proc
    logic en_q;
    en_q = iclkena && !ireset;
    if (en_q) begin
      edge_cnt++;
      if (ival) exp_q.push_back(model_beat(icode));
    end
    #2;
    if (en_q) check_outputs();
  end

  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout after %0d cycles with %0d beats still expected", cycle_cnt,
               exp_q.size());
      $display("sim failed");
      $finish;
    end
  end

  // --------------------
  // stimulus
  // --------------------

  task automatic drive_idle();
    ival    = 1'b0;
    isop    = 1'b0;
    ieop    = 1'b0;
    iclkena = 1'b1;
  endtask

  // one cycle of random input, frame state moves only on taken beats
  task automatic drive_cycle(input int val_pct, input int en_pct, input bit narrow);
    logic [31:0] r;
    int          len;
    bit          v;
    bit          e;
    v = chance(val_pct);
    e = chance(en_pct);
    for (int z = 0; z < 4; z++) begin
      for (int p = 0; p < 8; p++) begin
        r = next_rand();
        isymb_m[z][p] = narrow ? symb_m_t'(r[17:16]) : r[23:16];  // 0..3 forces ties
      end
      r = next_rand();
      isymb_m_sign[z] = r[21:20];
    end
    r       = next_rand();
    len     = (frame_left == 0) ? 1 + int'(r[18:17]) : frame_left;
    ival    = v;
    iclkena = e;
    isop    = v ? (frame_left == 0) : r[5];   // junk framing on gaps
    ieop    = v ? (len == 1) : r[6];
    if (v && e) begin
      frame_left = len - 1;
      beats_sent++;
    end
  endtask

  task automatic apply_reset();
    ireset     = 1'b1;
    frame_left = 0;
    drive_idle();
    repeat (3) @(posedge iclk);
    #1;
    ireset = 1'b0;
  endtask

  task automatic run_test(input string name, input code_t code_a, input code_t code_b,
                          input int val_pct, input int en_pct, input bit narrow);
    int err0;
    int chk0;
    err0      = errors;
    chk0      = beats_checked;
    test_name = name;
    for (int half = 0; half < 2; half++) begin
      icode      = (half == 0) ? code_a : code_b;
      beats_sent = 0;
      while (beats_sent < BEATS / 2) begin
        @(posedge iclk);
        #1;
        drive_cycle(val_pct, en_pct, narrow);
      end
      // empty the pipeline before icode moves
      do begin
        @(posedge iclk);
        #1;
        drive_idle();
      end while (exp_q.size() != 0);
      repeat (4) begin
        @(posedge iclk);
        #1;
      end
    end
    $display("test %s: %0d beats, %0d errors", name, beats_checked - chk0, errors - err0);
  endtask

  initial begin
    lcg_state     = 32'h165c;
    errors        = 0;
    beats_checked = 0;
    beats_sent    = 0;
    edge_cnt      = 0;
    cycle_cnt     = 0;
    test_name     = "init";
    icode         = CODE_G2;
    for (int z = 0; z < 4; z++) begin
      isymb_m_sign[z] = '0;
      for (int p = 0; p < 8; p++) isymb_m[z][p] = '0;
    end
    apply_reset();
    run_test("short_codes", CODE_G2, CODE_G4, 75, 100, 1'b0);
    run_test("long_codes", CODE_G8, CODE_G16, 75, 100, 1'b0);
    run_test("hard_ties", CODE_G4, CODE_G16, 75, 100, 1'b1);
    run_test("framing", CODE_G8, CODE_G2, 60, 100, 1'b0);
    run_test("stall", CODE_G16, CODE_G4, 100, 70, 1'b0);
    test_name = "reset_idle";
    apply_reset();
    repeat (10) @(posedge iclk);   // any oval here is flagged by the checker
    #1;
    run_test("reset_idle", CODE_G8, CODE_G2, 50, 100, 1'b0);
    $display("tests: 6, beats checked: %0d, errors: %0d", beats_checked, errors);
    if (errors == 0 && beats_checked == 6 * BEATS) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
tcm_dec_pkg.sv
tcm_dec_tmu_tree.sv
tcm_dec_tmu_hd.sv
tcm_dec_tmu.sv
tb_tcm_dec_tmu.sv

// File: run.sh
#!/bin/sh
# build and run the trellis metric unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_tcm_dec_tmu -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -qx "sim passed"
